// File: common/ctrl_pkg.sv
package ctrl_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [2:0]  alu_op_t;
    typedef logic [3:0]  wb_sel_t;
    typedef logic [1:0]  store_sel_t;
    typedef logic [1:0]  src_a_t;
    typedef logic [2:0]  src_b_t;

    // ALU operation codes
    localparam alu_op_t ALU_NOP = 3'd0;
    localparam alu_op_t ALU_ADD = 3'd1;
    localparam alu_op_t ALU_SUB = 3'd2;
    localparam alu_op_t ALU_AND = 3'd3;
    localparam alu_op_t ALU_SLT = 3'd6;

    // Register file write-back sources
    localparam wb_sel_t WB_ALU  = 4'd0;
    localparam wb_sel_t WB_SET1 = 4'd2;
    localparam wb_sel_t WB_SET0 = 4'd3;
    localparam wb_sel_t WB_LINK = 4'd4;
    localparam wb_sel_t WB_LD   = 4'd5;
    localparam wb_sel_t WB_LB   = 4'd6;
    localparam wb_sel_t WB_LH   = 4'd7;
    localparam wb_sel_t WB_LW   = 4'd8;
    localparam wb_sel_t WB_LBU  = 4'd9;
    localparam wb_sel_t WB_LHU  = 4'd10;
    localparam wb_sel_t WB_LWU  = 4'd11;

    // Store widths
    localparam store_sel_t ST_D = 2'd0;
    localparam store_sel_t ST_W = 2'd1;
    localparam store_sel_t ST_H = 2'd2;
    localparam store_sel_t ST_B = 2'd3;

    localparam src_a_t SRC_A_PC   = 2'd0;
    localparam src_a_t SRC_A_REG  = 2'd1;
    localparam src_a_t SRC_A_ZERO = 2'd3;

    localparam src_b_t SRC_B_REG   = 3'd0;
    localparam src_b_t SRC_B_FOUR  = 3'd1;
    localparam src_b_t SRC_B_IMM   = 3'd2;
    localparam src_b_t SRC_B_BROFF = 3'd3; // Shifted branch offset

    // Major opcodes
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    localparam logic [2:0] FUNCT3_ADD = 3'b000;
    localparam logic [2:0] FUNCT3_AND = 3'b111;
    localparam logic [2:0] FUNCT3_SLT = 3'b010;
    localparam logic [2:0] FUNCT3_BEQ = 3'b000;
    localparam logic [2:0] FUNCT3_BNE = 3'b001;

    localparam int FUNCT7_SUB_BIT = 5; // Bit 30 of the word

    typedef enum logic [3:0] {
        CLS_ALU_R,
        CLS_ALU_IMM,
        CLS_SLT,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JALR,
        CLS_LUI,
        CLS_NONE
    } instr_class_e;

    typedef enum logic [3:0] {
        ST_RESET,
        ST_WAIT,
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_ALU_WB,
        ST_SET1_WB,
        ST_SET0_WB,
        ST_LUI_WB,
        ST_LINK_JUMP,
        ST_LOAD_WAIT,
        ST_LOAD_READ,
        ST_LOAD_WB,
        ST_STORE_READ,
        ST_STORE_WAIT,
        ST_STORE_WRITE
    } state_e;

endpackage

// File: src/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
    input  ctrl_pkg::instr_t     instr,
    output ctrl_pkg::instr_class_e instr_class,
    output ctrl_pkg::alu_op_t    exec_op,
    output ctrl_pkg::wb_sel_t    load_sel,
    output ctrl_pkg::store_sel_t store_sel
);
    import ctrl_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        instr_class = CLS_NONE;
        exec_op     = ALU_NOP;
        load_sel    = WB_LD;
        store_sel   = ST_D;
        case (opcode)
            OP_REG: begin
                if (funct3 == FUNCT3_ADD) begin
                    instr_class = CLS_ALU_R;
                    exec_op     = funct7[FUNCT7_SUB_BIT] ? ALU_SUB : ALU_ADD;
                end else if (funct3 == FUNCT3_AND && !funct7[FUNCT7_SUB_BIT]) begin
                    instr_class = CLS_ALU_R;
                    exec_op     = ALU_AND;
                end else if (funct3 == FUNCT3_SLT && !funct7[FUNCT7_SUB_BIT]) begin
                    instr_class = CLS_SLT;
                    exec_op     = ALU_SLT;
                end
            end
            OP_IMM: begin
                if (funct3 == FUNCT3_ADD) begin
                    instr_class = CLS_ALU_IMM;
                    exec_op     = ALU_ADD;
                end else if (funct3 == FUNCT3_SLT) begin
                    instr_class = CLS_SLT; // slti
                    exec_op     = ALU_SLT;
                end
            end
            OP_LOAD: begin
                if (funct3 != 3'b111) begin
                    instr_class = CLS_LOAD;
                    exec_op     = ALU_ADD; // Address is rs1 + imm
                end
                case (funct3)
                    3'b000:  load_sel = WB_LB;
                    3'b001:  load_sel = WB_LH;
                    3'b010:  load_sel = WB_LW;
                    3'b100:  load_sel = WB_LBU;
                    3'b101:  load_sel = WB_LHU;
                    3'b110:  load_sel = WB_LWU;
                    default: load_sel = WB_LD;
                endcase
            end
            OP_STORE: begin
                if (!funct3[2]) begin
                    instr_class = CLS_STORE;
                    exec_op     = ALU_ADD;
                end
                case (funct3[1:0])
                    2'b00:   store_sel = ST_B;
                    2'b01:   store_sel = ST_H;
                    2'b10:   store_sel = ST_W;
                    default: store_sel = ST_D;
                endcase
            end
            OP_BRANCH: begin
                if (funct3 == FUNCT3_BEQ || funct3 == FUNCT3_BNE) begin
                    instr_class = CLS_BRANCH;
                    exec_op     = ALU_SUB; // Compare through the zero flag
                end
            end
            OP_JALR: begin
                if (funct3 == 3'b000) begin
                    instr_class = CLS_JALR;
                    exec_op     = ALU_ADD;
                end
            end
            OP_LUI: begin
                instr_class = CLS_LUI;
                exec_op     = ALU_ADD; // Zero plus upper immediate
            end
            default: begin
                instr_class = CLS_NONE;
            end
        endcase
    end

endmodule

// File: control/state_sequencer.sv
`timescale 1ns/10ps

module state_sequencer (
    input  logic                   CLK,
    input  logic                   RST,
    input  ctrl_pkg::instr_class_e instr_class,
    input  logic                   alu_less,
    output ctrl_pkg::state_e       state
);
    import ctrl_pkg::*;

    state_e next_state;

    always_ff @(posedge CLK, posedge RST) begin
        if (RST) begin
            state <= ST_RESET;
        end else begin
            state <= next_state;
        end
    end

    // Tail of the instruction depends on its class
    always_comb begin
        next_state = ST_WAIT;
        case (state)
            ST_RESET: begin
                next_state = ST_WAIT;
            end
            ST_WAIT: begin
                next_state = ST_FETCH;
            end
            ST_FETCH: begin
                next_state = ST_DECODE;
            end
            ST_DECODE: begin
                next_state = ST_EXECUTE;
            end
            ST_EXECUTE: begin
                case (instr_class)
                    CLS_ALU_R,
                    CLS_ALU_IMM: next_state = ST_ALU_WB;
                    CLS_SLT:     next_state = alu_less ? ST_SET1_WB : ST_SET0_WB;
                    CLS_LUI:     next_state = ST_LUI_WB;
                    CLS_JALR:    next_state = ST_LINK_JUMP;
                    CLS_LOAD:    next_state = ST_LOAD_WAIT;
                    CLS_STORE:   next_state = ST_STORE_READ;
                    default:     next_state = ST_WAIT; // Branch done, or no-op
                endcase
            end
            ST_LOAD_WAIT: begin
                next_state = ST_LOAD_READ;
            end
            ST_LOAD_READ: begin
                next_state = ST_LOAD_WB;
            end
            ST_STORE_READ: begin
                next_state = ST_STORE_WAIT;
            end
            ST_STORE_WAIT: begin
                next_state = ST_STORE_WRITE;
            end
            ST_ALU_WB,
            ST_SET1_WB,
            ST_SET0_WB,
            ST_LUI_WB,
            ST_LINK_JUMP,
            ST_LOAD_WB,
            ST_STORE_WRITE: begin
                next_state = ST_WAIT;
            end
            default: begin
                next_state = ST_WAIT;
            end
        endcase
    end

    // The machine never stalls
    property p_state_advances;
        @(posedge CLK) disable iff (RST)
        (state != ST_RESET) |=> (state != $past(state));
    endproperty

    a_state_advances: assert property (p_state_advances)
        else $error("state %s held for two cycles", state.name());

endmodule

// File: control/control_signals.sv
`timescale 1ns/10ps

module control_signals (
    input  ctrl_pkg::state_e       state,
    input  ctrl_pkg::instr_class_e instr_class,
    input  ctrl_pkg::alu_op_t      exec_op,
    input  ctrl_pkg::wb_sel_t      load_sel,
    input  ctrl_pkg::store_sel_t   store_sel_in,
    input  ctrl_pkg::instr_t       instr,
    input  logic                   alu_zero,
    output logic                   datapath_reset,
    output logic                   ir_load,
    output logic                   pc_write,
    output logic                   pc_src_alu,
    output logic                   a_write,
    output logic                   b_write,
    output logic                   alu_out_write,
    output logic                   reg_write,
    output logic                   mdr_write,
    output logic                   mem_write,
    output ctrl_pkg::alu_op_t      alu_op,
    output ctrl_pkg::src_a_t       alu_src_a,
    output ctrl_pkg::src_b_t       alu_src_b,
    output ctrl_pkg::wb_sel_t      wb_sel,
    output ctrl_pkg::store_sel_t   store_sel
);
    import ctrl_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       branch_taken;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    assign branch_taken = (funct3 == FUNCT3_BEQ &&  alu_zero) ||
                          (funct3 == FUNCT3_BNE && !alu_zero);

    always_comb begin
        datapath_reset = 1'b0;
        ir_load        = 1'b0;
        pc_write       = 1'b0;
        pc_src_alu     = 1'b1; // Low picks the registered ALU result
        a_write        = 1'b0;
        b_write        = 1'b0;
        alu_out_write  = 1'b0;
        reg_write      = 1'b0;
        mdr_write      = 1'b0;
        mem_write      = 1'b0;
        alu_op         = ALU_NOP;
        alu_src_a      = SRC_A_PC;
        alu_src_b      = SRC_B_REG;
        wb_sel         = WB_ALU;
        store_sel      = ST_D;
        case (state)
            ST_RESET: begin
                datapath_reset = 1'b1;
            end
            ST_FETCH: begin
                ir_load   = 1'b1;
                pc_write  = 1'b1; // PC + 4
                alu_op    = ALU_ADD;
                alu_src_b = SRC_B_FOUR;
            end
            ST_DECODE: begin
                a_write       = 1'b1;
                b_write       = 1'b1;
                alu_out_write = 1'b1; // Branch target held for execute
                alu_op        = ALU_ADD;
                alu_src_b     = SRC_B_BROFF;
            end
            ST_EXECUTE: begin
                alu_op = exec_op;
                case (instr_class)
                    CLS_ALU_R: begin
                        alu_out_write = 1'b1;
                        alu_src_a     = SRC_A_REG;
                    end
                    CLS_SLT: begin
                        alu_out_write = 1'b1;
                        alu_src_a     = SRC_A_REG;
                        alu_src_b     = (opcode == OP_REG) ? SRC_B_REG : SRC_B_IMM;
                    end
                    CLS_ALU_IMM,
                    CLS_LOAD,
                    CLS_STORE,
                    CLS_JALR: begin
                        alu_out_write = 1'b1;
                        alu_src_a     = SRC_A_REG;
                        alu_src_b     = SRC_B_IMM;
                    end
                    CLS_LUI: begin
                        alu_out_write = 1'b1;
                        alu_src_a     = SRC_A_ZERO;
                        alu_src_b     = SRC_B_IMM;
                    end
                    CLS_BRANCH: begin
                        alu_src_a = SRC_A_REG;
                        if (branch_taken) begin
                            pc_write   = 1'b1;
                            pc_src_alu = 1'b0;
                        end
                    end
                    default: begin
                        alu_op = ALU_NOP;
                    end
                endcase
            end
            ST_ALU_WB,
            ST_LUI_WB: begin
                reg_write = 1'b1;
                wb_sel    = WB_ALU;
            end
            ST_SET1_WB: begin
                reg_write = 1'b1;
                wb_sel    = WB_SET1;
            end
            ST_SET0_WB: begin
                reg_write = 1'b1;
                wb_sel    = WB_SET0;
            end
            ST_LINK_JUMP: begin
                reg_write  = 1'b1; // rd gets the return address
                pc_write   = 1'b1;
                pc_src_alu = 1'b0;
                wb_sel     = WB_LINK;
            end
            ST_LOAD_READ,
            ST_STORE_READ: begin
                mdr_write = 1'b1;
            end
            ST_LOAD_WB: begin
                reg_write = 1'b1;
                wb_sel    = load_sel;
            end
            ST_STORE_WRITE: begin
                mem_write = 1'b1;
                store_sel = store_sel_in;
            end
            default: begin
                datapath_reset = 1'b0;
            end
        endcase
    end

    // Sampled on every state change, so each state is checked once it is left
    a_mem_reg_excl: assert property (@(state) mem_write |-> !reg_write)
        else $error("mem_write and reg_write both high");

    a_no_pc_in_wb: assert property (@(state)
        (state inside {ST_ALU_WB, ST_SET1_WB, ST_SET0_WB, ST_LUI_WB, ST_LOAD_WB})
        |-> !pc_write)
        else $error("pc_write high in writeback state");

endmodule

// File: src/control_unit.sv
`timescale 1ns/10ps

module control_unit (
    input  logic                 CLK,
    input  logic                 RST,
    input  ctrl_pkg::instr_t     instr,
    input  logic                 alu_zero,
    input  logic                 alu_less,
    output logic                 datapath_reset,
    output logic                 ir_load,
    output logic                 pc_write,
    output logic                 pc_src_alu,
    output logic                 a_write,
    output logic                 b_write,
    output logic                 alu_out_write,
    output logic                 reg_write,
    output logic                 mdr_write,
    output logic                 mem_write,
    output ctrl_pkg::alu_op_t    alu_op,
    output ctrl_pkg::src_a_t     alu_src_a,
    output ctrl_pkg::src_b_t     alu_src_b,
    output ctrl_pkg::wb_sel_t    wb_sel,
    output ctrl_pkg::store_sel_t store_sel
);
    import ctrl_pkg::*;

    instr_class_e instr_class;
    alu_op_t      exec_op;
    wb_sel_t      load_sel;
    store_sel_t   dec_store_sel;
    state_e       state;

    instr_decoder u_decoder (
        .instr       (instr),
        .instr_class (instr_class),
        .exec_op     (exec_op),
        .load_sel    (load_sel),
        .store_sel   (dec_store_sel)
    );

    state_sequencer u_sequencer (
        .CLK         (CLK),
        .RST         (RST),
        .instr_class (instr_class),
        .alu_less    (alu_less),
        .state       (state)
    );

    control_signals u_signals (
        .state          (state),
        .instr_class    (instr_class),
        .exec_op        (exec_op),
        .load_sel       (load_sel),
        .store_sel_in   (dec_store_sel),
        .instr          (instr),
        .alu_zero       (alu_zero),
        .datapath_reset (datapath_reset),
        .ir_load        (ir_load),
        .pc_write       (pc_write),
        .pc_src_alu     (pc_src_alu),
        .a_write        (a_write),
        .b_write        (b_write),
        .alu_out_write  (alu_out_write),
        .reg_write      (reg_write),
        .mdr_write      (mdr_write),
        .mem_write      (mem_write),
        .alu_op         (alu_op),
        .alu_src_a      (alu_src_a),
        .alu_src_b      (alu_src_b),
        .wb_sel         (wb_sel),
        .store_sel      (store_sel)
    );

endmodule

// File: bench/control_checker.sv
`timescale 1ns/10ps

module control_checker (
    input  logic                 CLK,
    input  logic                 RST,
    input  ctrl_pkg::instr_t     instr,
    input  logic                 datapath_reset,
    input  logic                 ir_load,
    input  logic                 pc_write,
    input  logic                 pc_src_alu,
    input  logic                 a_write,
    input  logic                 b_write,
    input  logic                 alu_out_write,
    input  logic                 reg_write,
    input  logic                 mdr_write,
    input  logic                 mem_write,
    input  ctrl_pkg::alu_op_t    alu_op,
    input  ctrl_pkg::src_a_t     alu_src_a,
    input  ctrl_pkg::src_b_t     alu_src_b,
    input  ctrl_pkg::wb_sel_t    wb_sel,
    input  ctrl_pkg::store_sel_t store_sel
);
    import ctrl_pkg::*;

    int    pass_count = 0;
    int    fail_count = 0;
    int    done_count = 0;
    int    errs = 0;
    bit    reset_checked = 1'b0;
    int    since_reset = 0;
    bit    active = 1'b0;
    string cur_name = "reset";

    // Expectations of the running test
    int    exp_op;
    int    exp_wb;
    int    exp_st;
    int    exp_cycles;
    bit    exp_wb_none;
    bit    exp_st_none;
    bit    exp_pc;

    // What the DUT did so far
    int    cycles;
    int    n_reg;
    int    n_mem;
    int    n_mdr;
    int    seen_op;
    int    seen_wb;
    int    seen_st;
    bit    seen_exec_pc;
    bit    seen_wb_pc;

    task automatic start_test(input string name, input int op, input int wb, input bit wb_none,
                              input int st, input bit st_none, input bit pcw, input int cyc);
        cur_name     = name;
        exp_op       = op;
        exp_wb       = wb;
        exp_wb_none  = wb_none;
        exp_st       = st;
        exp_st_none  = st_none;
        exp_pc       = pcw;
        exp_cycles   = cyc;
        cycles       = 0;
        n_reg        = 0;
        n_mem        = 0;
        n_mdr        = 0;
        seen_op      = 0;
        seen_wb      = 0;
        seen_st      = 0;
        seen_exec_pc = 1'b0;
        seen_wb_pc   = 1'b0;
        errs         = 0;
        active       = 1'b1;
    endtask

    task automatic compare_field(input string field, input int expected, input int actual);
        if (expected != actual) begin
            $display("Error %s: %s expected %0d, actual %0d", cur_name, field, expected, actual);
            errs++;
        end
    endtask

    task automatic close_test();
        if (errs == 0) begin
            $display("test %s: ok", cur_name);
            pass_count++;
        end else begin
            $display("test %s: failed with %0d mismatches", cur_name, errs);
            fail_count++;
        end
        done_count++;
        errs = 0;
    endtask

    task automatic finish_test();
        compare_field("cycles", exp_cycles, cycles);
        compare_field("execute alu_op", exp_op, seen_op);
        compare_field("execute pc_write", exp_pc, seen_exec_pc);
        if (exp_wb_none) begin
            compare_field("reg_write count", 0, n_reg);
        end else begin
            compare_field("reg_write count", 1, n_reg);
            compare_field("wb_sel", exp_wb, seen_wb);
            compare_field("pc_write with reg_write", exp_wb == WB_LINK, seen_wb_pc);
        end
        if (exp_st_none) begin
            compare_field("mem_write count", 0, n_mem);
        end else begin
            compare_field("mem_write count", 1, n_mem);
            compare_field("store_sel", exp_st, seen_st);
        end
        compare_field("mdr_write count", exp_cycles == 7, n_mdr); // Only memory ops take 7
        close_test();
        active = 1'b0;
    endtask

    task automatic report_counts();
        $display("%0d tests passed, %0d failed", pass_count, fail_count);
    endtask

    // Outputs are combinational from the state, so sample mid-cycle
    always @(negedge CLK) begin
        if (RST) begin
            since_reset = 0;
            compare_field("datapath_reset during reset", 1, datapath_reset);
            compare_field("write strobes during reset", 0,
                          {ir_load, pc_write, a_write, b_write, alu_out_write,
                           reg_write, mdr_write, mem_write});
        end else begin
            since_reset++;
            if (ir_load && (active || !reset_checked)) begin // PC + 4
                compare_field("fetch pc_write", 1, pc_write);
                compare_field("fetch pc_src_alu", 1, pc_src_alu);
                compare_field("fetch alu_src_a", SRC_A_PC, alu_src_a);
                compare_field("fetch alu_src_b", SRC_B_FOUR, alu_src_b);
            end
            if (!reset_checked && ir_load) begin
                compare_field("cycles to first ir_load", 3, since_reset);
                close_test();
                reset_checked = 1'b1;
            end
            if (active) begin
                cycles++;
                if (ir_load) begin
                    finish_test(); // Next fetch ends the instruction
                end else begin
                    if (cycles == 1) begin // Decode
                        compare_field("decode a, b and alu_out writes", 3'b111,
                                      {a_write, b_write, alu_out_write});
                        compare_field("decode alu_src_b", SRC_B_BROFF, alu_src_b);
                    end
                    if (cycles == 2) begin // Execute
                        seen_op      = alu_op;
                        seen_exec_pc = pc_write;
                        compare_field("execute pc_src_alu", !exp_pc, pc_src_alu);
                        compare_field("execute alu_out_write", exp_cycles != 4, alu_out_write);
                        if (exp_cycles != 4) begin
                            compare_field("execute alu_src_a",
                                          (instr[6:0] == OP_LUI) ? SRC_A_ZERO : SRC_A_REG,
                                          alu_src_a);
                            compare_field("execute alu_src_b",
                                          (instr[6:0] == OP_REG) ? SRC_B_REG : SRC_B_IMM,
                                          alu_src_b);
                        end
                    end
                    if (reg_write) begin
                        n_reg++;
                        seen_wb    = wb_sel;
                        seen_wb_pc = pc_write;
                    end
                    if (mem_write) begin
                        n_mem++;
                        seen_st = store_sel;
                    end
                    if (mdr_write) begin
                        n_mdr++;
                    end
                end
            end
        end
    end

endmodule

// File: bench/control_unit_tb.sv
`timescale 1ns/10ps

module control_unit_tb;
    import ctrl_pkg::*;

    localparam int MAX_TESTS = 64;

    logic       CLK;
    logic       RST;
    instr_t     instr;
    logic       alu_zero;
    logic       alu_less;
    logic       datapath_reset;
    logic       ir_load;
    logic       pc_write;
    logic       pc_src_alu;
    logic       a_write;
    logic       b_write;
    logic       alu_out_write;
    logic       reg_write;
    logic       mdr_write;
    logic       mem_write;
    alu_op_t    alu_op;
    src_a_t     alu_src_a;
    src_b_t     alu_src_b;
    wb_sel_t    wb_sel;
    store_sel_t store_sel;

    // One entry per pattern line
    string      test_name [MAX_TESTS];
    instr_t     test_instr [MAX_TESTS];
    logic       test_zero [MAX_TESTS];
    logic       test_less [MAX_TESTS];
    int         test_op [MAX_TESTS];
    int         test_wb [MAX_TESTS];
    bit         test_wb_none [MAX_TESTS];
    int         test_st [MAX_TESTS];
    bit         test_st_none [MAX_TESTS];
    bit         test_pc [MAX_TESTS];
    int         test_cycles [MAX_TESTS];
    int         n_tests = 0;
    int         cycle_limit = 0;
    int         cycle_count = 0;

    control_unit dut (
        .CLK            (CLK),
        .RST            (RST),
        .instr          (instr),
        .alu_zero       (alu_zero),
        .alu_less       (alu_less),
        .datapath_reset (datapath_reset),
        .ir_load        (ir_load),
        .pc_write       (pc_write),
        .pc_src_alu     (pc_src_alu),
        .a_write        (a_write),
        .b_write        (b_write),
        .alu_out_write  (alu_out_write),
        .reg_write      (reg_write),
        .mdr_write      (mdr_write),
        .mem_write      (mem_write),
        .alu_op         (alu_op),
        .alu_src_a      (alu_src_a),
        .alu_src_b      (alu_src_b),
        .wb_sel         (wb_sel),
        .store_sel      (store_sel)
    );

    control_checker chk (
        .CLK            (CLK),
        .RST            (RST),
        .instr          (instr),
        .datapath_reset (datapath_reset),
        .ir_load        (ir_load),
        .pc_write       (pc_write),
        .pc_src_alu     (pc_src_alu),
        .a_write        (a_write),
        .b_write        (b_write),
        .alu_out_write  (alu_out_write),
        .reg_write      (reg_write),
        .mdr_write      (mdr_write),
        .mem_write      (mem_write),
        .alu_op         (alu_op),
        .alu_src_a      (alu_src_a),
        .alu_src_b      (alu_src_b),
        .wb_sel         (wb_sel),
        .store_sel      (store_sel)
    );

    always #4 CLK = ~CLK;

    task automatic load_patterns(output bit ok);
        int          fd;
        int          count;
        string       line;
        string       name;
        logic [31:0] word;
        int          z;
        int          l;
        int          op;
        int          pcw;
        int          cyc;
        int          code;
        string       wb_txt;
        string       st_txt;
        fd = $fopen("bench/control_patterns.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                count = 0;
                if (line.getc(0) != "#") begin // Column header lines
                    count = $sscanf(line, "%s %h %d %d %d %s %s %d %d",
                                    name, word, z, l, op, wb_txt, st_txt, pcw, cyc);
                end
                if (count == 9 && n_tests < MAX_TESTS) begin
                    test_name[n_tests]    = name;
                    test_instr[n_tests]   = word;
                    test_zero[n_tests]    = z[0];
                    test_less[n_tests]    = l[0];
                    test_op[n_tests]      = op;
                    test_pc[n_tests]      = pcw[0];
                    test_cycles[n_tests]  = cyc;
                    test_wb_none[n_tests] = (wb_txt == "none");
                    test_st_none[n_tests] = (st_txt == "none");
                    code = 0;
                    if (!test_wb_none[n_tests]) begin
                        count = $sscanf(wb_txt, "%d", code);
                    end
                    test_wb[n_tests] = code;
                    code = 0;
                    if (!test_st_none[n_tests]) begin
                        count = $sscanf(st_txt, "%d", code);
                    end
                    test_st[n_tests] = code;
                    cycle_limit += cyc;
                    n_tests++;
                end
            end
            $fclose(fd);
        end
        cycle_limit += 20;
        ok = (fd != 0) && (n_tests > 0);
    endtask

    // Returns on the edge that closes ST_FETCH
    task automatic wait_for_fetch();
        do begin
            @(posedge CLK);
        end while (ir_load !== 1'b1);
    endtask

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: tests did not finish within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        bit ok;
        CLK      = 1'b0;
        RST      = 1'b1;
        instr    = '0;
        alu_zero = 1'b0;
        alu_less = 1'b0;
        load_patterns(ok);
        if (!ok) begin
            $display("could not read any test from bench/control_patterns.txt");
            $display("=== FAIL ===");
            $finish;
        end else begin
            repeat (3) @(posedge CLK);
            RST <= 1'b0;
            for (int i = 0; i < n_tests; i++) begin
                wait_for_fetch();
                instr    <= test_instr[i];
                alu_zero <= test_zero[i];
                alu_less <= test_less[i];
                chk.start_test(test_name[i], test_op[i], test_wb[i], test_wb_none[i],
                               test_st[i], test_st_none[i], test_pc[i], test_cycles[i]);
            end
            while (chk.done_count < n_tests + 1) begin // Reset counts as a test
                @(posedge CLK);
            end
            chk.report_counts();
            if (chk.fail_count == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

endmodule

// File: bench/control_patterns.txt
# name instr(hex) alu_zero alu_less exec_alu_op wb_sel|none store_sel|none exec_pc_write cycles
# alu_op, wb_sel and store_sel are decimal codes; "none" means no write of that kind
add      002081b3 0 0 1 0    none 0 5
sub      402081b3 0 0 2 0    none 0 5
and      0020f1b3 0 0 3 0    none 0 5
addi     00508193 0 0 1 0    none 0 5
lui      123451b7 0 0 1 0    none 0 5
slt_lt   0020a1b3 0 1 6 2    none 0 5
slt_ge   0020a1b3 0 0 6 3    none 0 5
slti_lt  0050a193 0 1 6 2    none 0 5
slti_ge  0050a193 0 0 6 3    none 0 5
lb       00808183 0 0 1 6    none 0 7
lh       00809183 0 0 1 7    none 0 7
lw       0080a183 0 0 1 8    none 0 7
ld       0080b183 0 0 1 5    none 0 7
lbu      0080c183 0 0 1 9    none 0 7
lhu      0080d183 0 0 1 10   none 0 7
lwu      0080e183 0 0 1 11   none 0 7
sb       00208423 0 0 1 none 3    0 7
sh       00209423 0 0 1 none 2    0 7
sw       0020a423 0 0 1 none 1    0 7
sd       0020b423 0 0 1 none 0    0 7
beq_tkn  00208863 1 0 2 none none 1 4
beq_not  00208863 0 0 2 none none 0 4
bne_tkn  00209863 0 0 2 none none 1 4
bne_not  00209863 1 0 2 none none 0 4
jalr     000100e7 0 0 1 4    none 0 5
ecall    00000073 0 0 0 none none 0 4

// File: riscv_control.f
common/ctrl_pkg.sv
src/instr_decoder.sv
control/state_sequencer.sv
control/control_signals.sv
src/control_unit.sv
bench/control_checker.sv
bench/control_unit_tb.sv

// File: Bender.yml
package:
  name: riscv_control

sources:
  - common/ctrl_pkg.sv
  - src/instr_decoder.sv
  - control/state_sequencer.sv
  - control/control_signals.sv
  - src/control_unit.sv
  - target: test
    files:
      - bench/control_checker.sv
      - bench/control_unit_tb.sv
